// File: build.f
hw/fp32_pkg.sv
hw/fpu_op_pkg.sv
hw/fpu_unit_if.sv
hw/fp_compare.sv
hw/fp_sign_class_unit.sv
hw/fpu_sequencer.sv
hw/fpu_top.sv
verification/tb_clock_gen.sv
verification/fpu_tb.sv

// File: verification/fpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;
  import fp32_pkg::*;
  import fpu_op_pkg::*;

  localparam int NUM_OPS        = 11;
  localparam int NUM_SPECIAL    = 8;
  localparam int NUM_RANDOM     = 24;
  localparam int TOTAL_OPS      = NUM_OPS * (NUM_SPECIAL * NUM_SPECIAL + NUM_RANDOM);
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_OPS + 100;

  logic                      clk;
  logic                      rst;
  logic                      valid;
  logic [OP_WIDTH-1:0]       operation;
  logic [FP_WIDTH-1:0]       operand_a;
  logic [FP_WIDTH-1:0]       operand_b;
  logic [REG_ADDR_WIDTH-1:0] dest_reg;
  logic                      out_valid;
  logic [FP_WIDTH-1:0]       result;
  logic                      result_to_int;
  logic [REG_ADDR_WIDTH-1:0] out_dest_reg;
  logic [FLAG_WIDTH-1:0]     flags;
  logic                      stall;
  logic [REG_ADDR_WIDTH-1:0] inflight_dest;

  // Expected {dest, flags, to_int, result} per issued operation
  logic [42:0] exp_q[$];
  logic [31:0] rng_state = 32'h16ea_8d46;
  int          cycle_count = 0;

  tb_clock_gen clk_gen_i (
    .o_clk (clk),
    .o_rst (rst)
  );

  fpu_top dut_i (
    .i_clk           (clk),
    .i_rst           (rst),
    .i_valid         (valid),
    .i_operation     (operation),
    .i_operand_a     (operand_a),
    .i_operand_b     (operand_b),
    .i_dest_reg      (dest_reg),
    .o_valid         (out_valid),
    .o_result        (result),
    .o_result_to_int (result_to_int),
    .o_dest_reg      (out_dest_reg),
    .o_flags         (flags),
    .o_stall         (stall),
    .o_inflight_dest (inflight_dest)
  );

  // ====================
  // Stimulus helpers
  // ====================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Signed zeros, infinities, NaNs, a subnormal and 1.0
  function automatic logic [31:0] special_value(input int idx);
    case (idx)
      0:       return 32'h0000_0000;
      1:       return 32'h8000_0000;
      2:       return 32'h7F80_0000;
      3:       return 32'hFF80_0000;
      4:       return 32'h7FC0_0000;
      5:       return 32'h7F80_0001;
      6:       return 32'h0040_0000;
      default: return 32'h3F80_0000;
    endcase
  endfunction

  function automatic logic [OP_WIDTH-1:0] op_at(input int idx);
    case (idx)
      0:       return OP_FEQ;
      1:       return OP_FLT;
      2:       return OP_FLE;
      3:       return OP_FMIN;
      4:       return OP_FMAX;
      5:       return OP_FSGNJ;
      6:       return OP_FSGNJN;
      7:       return OP_FSGNJX;
      8:       return OP_FCLASS;
      9:       return OP_FMV_X_W;
      default: return OP_FMV_W_X;
    endcase
  endfunction

  // About one operand in four comes from the special table
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = next_rand();
    if (r[1:0] == 2'b00) begin
      return special_value(r[4:2]);
    end
    return next_rand();
  endfunction

  // ====================
  // Reference model
  // ====================
  // Total order on non-NaN values, both zeros map to 0
  function automatic logic signed [32:0] order_key(input logic [31:0] w);
    logic signed [32:0] mag;
    mag = {2'b00, w[30:0]};
    return w[31] ? -mag : mag;
  endfunction

  function automatic int class_index(input logic [31:0] w);
    if (w[30:23] == 8'hFF) begin
      if (w[22:0] == 23'd0) return w[31] ? CLS_NEG_INF : CLS_POS_INF;
      return w[22] ? CLS_QNAN : CLS_SNAN;
    end
    if (w[30:23] == 8'h00) begin
      if (w[22:0] == 23'd0) return w[31] ? CLS_NEG_ZERO : CLS_POS_ZERO;
      return w[31] ? CLS_NEG_SUB : CLS_POS_SUB;
    end
    return w[31] ? CLS_NEG_NORM : CLS_POS_NORM;
  endfunction

  // Returns {flags, to_int, result}
  function automatic logic [37:0] fpu_ref(input logic [OP_WIDTH-1:0] op,
                                          input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0]           res;
    logic                  to_int;
    logic                  nv;
    logic                  a_nan;
    logic                  b_nan;
    logic                  any_snan;
    logic signed [32:0]    ka;
    logic signed [32:0]    kb;
    logic                  a_lower;
    logic [FLAG_WIDTH-1:0] fl;
    a_nan    = (a[30:23] == 8'hFF) && (a[22:0] != 23'd0);
    b_nan    = (b[30:23] == 8'hFF) && (b[22:0] != 23'd0);
    any_snan = (a_nan && !a[22]) || (b_nan && !b[22]);
    ka       = order_key(a);
    kb       = order_key(b);
    // Minus zero sorts below plus zero for min/max
    a_lower  = (ka < kb) || ((ka == kb) && a[31] && !b[31]);
    res      = 32'd0;
    to_int   = 1'b0;
    nv       = 1'b0;
    case (op)
      OP_FEQ: begin
        to_int = 1'b1;
        res[0] = !a_nan && !b_nan && (ka == kb);
        nv     = any_snan;
      end
      OP_FLT: begin
        to_int = 1'b1;
        res[0] = !a_nan && !b_nan && (ka < kb);
        nv     = a_nan || b_nan;
      end
      OP_FLE: begin
        to_int = 1'b1;
        res[0] = !a_nan && !b_nan && (ka <= kb);
        nv     = a_nan || b_nan;
      end
      OP_FMIN, OP_FMAX: begin
        nv = any_snan;
        if (a_nan && b_nan) res = 32'h7FC0_0000;
        else if (a_nan) res = b;
        else if (b_nan) res = a;
        else if (op == OP_FMIN) res = a_lower ? a : b;
        else res = a_lower ? b : a;
      end
      OP_FSGNJ:  res = {b[31], a[30:0]};
      OP_FSGNJN: res = {~b[31], a[30:0]};
      OP_FSGNJX: res = {a[31] ^ b[31], a[30:0]};
      OP_FCLASS: begin
        to_int = 1'b1;
        res    = 32'd1 << class_index(a);
      end
      OP_FMV_X_W: begin
        to_int = 1'b1;
        res    = a;
      end
      default: res = a;
    endcase
    fl          = '0;
    fl[FLAG_NV] = nv;
    return {fl, to_int, res};
  endfunction

  // ====================
  // Checks
  // ====================
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // No result, no stall and nothing in flight
  task automatic hold_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value("o_valid", out_valid, 0);
      check_value("o_stall", stall, 0);
      check_value("o_inflight_dest", inflight_dest, 0);
    end
  endtask

  task automatic present_non_fp(input logic [OP_WIDTH-1:0] op);
    @(negedge clk);
    valid     = 1'b1;
    operation = op;
    operand_a = next_rand();
    operand_b = next_rand();
    dest_reg  = 5'd7;
    hold_quiet(10);
  endtask

  // Accepted at the next rising edge, result 3 or 2 edges later
  task automatic run_op(input logic [OP_WIDTH-1:0] op, input logic [31:0] a,
                        input logic [31:0] b, input logic [REG_ADDR_WIDTH-1:0] dest);
    int          lat;
    logic [37:0] ref_val;
    lat = (op == OP_FEQ || op == OP_FLT || op == OP_FLE ||
           op == OP_FMIN || op == OP_FMAX) ? 3 : 2;
    ref_val = fpu_ref(op, a, b);
    @(negedge clk);
    valid     = 1'b1;
    operation = op;
    operand_a = a;
    operand_b = b;
    dest_reg  = dest;
    exp_q.push_back({dest, ref_val});
    // Stall rises within the acceptance cycle, before the edge
    #1;
    check_value("o_valid", out_valid, 0);
    check_value("o_stall", stall, 1);
    repeat (lat) begin
      @(negedge clk);
      check_value("o_valid", out_valid, 0);
      check_value("o_stall", stall, 1);
      check_value("o_inflight_dest", inflight_dest, dest);
    end
    @(negedge clk);
    check_value("o_valid", out_valid, 1);
    check_value("o_stall", stall, 0);
    check_value("o_inflight_dest", inflight_dest, 0);
  endtask

  // Result fields against the oldest expected entry
  initial begin
    logic [42:0] exp_val;
    forever begin
      @(negedge clk);
      if (out_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Simulation failed");
          $fatal(1, "A result came out with no operation outstanding");
        end else begin
          exp_val = exp_q.pop_front();
          check_value("o_result", result, exp_val[31:0]);
          check_value("o_result_to_int", result_to_int, exp_val[32]);
          check_value("o_flags", flags, exp_val[37:33]);
          check_value("o_dest_reg", out_dest_reg, exp_val[42:38]);
        end
      end
    end
  end

  // Run limit
  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Simulation failed");
    $fatal(1, "Timed out after %0d cycles without finishing the tests", cycle_count);
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    int          i;
    int          j;
    int          k;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    valid     = 1'b0;
    operation = '0;
    operand_a = '0;
    operand_b = '0;
    dest_reg  = '0;
    @(negedge rst);
    check_value("o_valid", out_valid, 0);
    check_value("o_stall", stall, 0);
    check_value("o_inflight_dest", inflight_dest, 0);
    check_value("o_dest_reg", out_dest_reg, 0);
    // Idle input, then codes outside the FP set
    hold_quiet(10);
    present_non_fp(5'd0);
    present_non_fp(5'd12);
    present_non_fp(5'd31);
    // Every operation on every pair of special values, back to back
    for (i = 0; i < NUM_OPS; i++) begin
      for (j = 0; j < NUM_SPECIAL; j++) begin
        for (k = 0; k < NUM_SPECIAL; k++) begin
          r = next_rand();
          run_op(op_at(i), special_value(j), special_value(k), r[4:0]);
        end
      end
    end
    // Random operands mixed with specials
    for (i = 0; i < NUM_OPS; i++) begin
      for (j = 0; j < NUM_RANDOM; j++) begin
        a = pick_operand();
        b = pick_operand();
        r = next_rand();
        run_op(op_at(i), a, b, r[4:0]);
      end
    end
    // Last operation must not be issued again
    @(negedge clk);
    valid = 1'b0;
    hold_quiet(10);
    if (exp_q.size() != 0) begin
      $display("Simulation failed");
      $fatal(1, "%0d operations never produced a result", exp_q.size());
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule : fpu_tb

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst
);

  // 20 ns period
  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  // Reset covers two rising edges, released on a falling edge
  initial begin
    o_rst = 1'b1;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule : tb_clock_gen

`default_nettype wire

// File: hw/fpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  // Operation request
  input  logic                                  i_valid,
  input  logic [fpu_op_pkg::OP_WIDTH-1:0]       i_operation,
  input  logic [fp32_pkg::FP_WIDTH-1:0]         i_operand_a,
  input  logic [fp32_pkg::FP_WIDTH-1:0]         i_operand_b,
  input  logic [fpu_op_pkg::REG_ADDR_WIDTH-1:0] i_dest_reg,
  // Result, one-cycle pulse
  output logic                                  o_valid,
  output logic [fp32_pkg::FP_WIDTH-1:0]         o_result,
  output logic                                  o_result_to_int,
  output logic [fpu_op_pkg::REG_ADDR_WIDTH-1:0] o_dest_reg,
  output logic [fpu_op_pkg::FLAG_WIDTH-1:0]     o_flags,
  // Pipeline control and hazard view
  output logic                                  o_stall,
  output logic [fpu_op_pkg::REG_ADDR_WIDTH-1:0] o_inflight_dest
);

  // One link per execution unit
  fpu_unit_if cmp_if ();
  fpu_unit_if scu_if ();

  // ====================
  // Sequencer
  // ====================
  fpu_sequencer seq_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_operation     (i_operation),
    .i_operand_a     (i_operand_a),
    .i_operand_b     (i_operand_b),
    .i_dest_reg      (i_dest_reg),
    .o_valid         (o_valid),
    .o_result        (o_result),
    .o_result_to_int (o_result_to_int),
    .o_dest_reg      (o_dest_reg),
    .o_flags         (o_flags),
    .o_stall         (o_stall),
    .o_inflight_dest (o_inflight_dest),
    .cmp             (cmp_if.sequencer),
    .scu             (scu_if.sequencer)
  );

  // ====================
  // Execution units
  // ====================
  // Compare and min/max, 3 cycles
  fp_compare cmp_i (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .port  (cmp_if.unit)
  );

  // Sign injection, classify and moves, 2 cycles
  fp_sign_class_unit scu_i (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .port  (scu_if.unit)
  );

endmodule : fpu_top

`default_nettype wire

// File: hw/fpu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_sequencer (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_valid,
  input  logic [fpu_op_pkg::OP_WIDTH-1:0]     i_operation,
  input  logic [fp32_pkg::FP_WIDTH-1:0]       i_operand_a,
  input  logic [fp32_pkg::FP_WIDTH-1:0]       i_operand_b,
  input  logic [fpu_op_pkg::REG_ADDR_WIDTH-1:0] i_dest_reg,
  output logic                                o_valid,
  output logic [fp32_pkg::FP_WIDTH-1:0]       o_result,
  output logic                                o_result_to_int,
  output logic [fpu_op_pkg::REG_ADDR_WIDTH-1:0] o_dest_reg,
  output logic [fpu_op_pkg::FLAG_WIDTH-1:0]   o_flags,
  output logic                                o_stall,
  output logic [fpu_op_pkg::REG_ADDR_WIDTH-1:0] o_inflight_dest,
  fpu_unit_if.sequencer                       cmp,
  fpu_unit_if.sequencer                       scu
);
  import fpu_op_pkg::*;

  // ====================
  // Decode
  // ====================
  logic use_cmp;
  logic use_scu;
  logic to_int;
  logic is_fp_op;

  always_comb begin
    use_cmp = 1'b0;
    use_scu = 1'b0;
    to_int  = 1'b0;
    case (i_operation)
      // Compares write the integer file, min/max the FP file
      OP_FEQ, OP_FLT, OP_FLE: begin
        use_cmp = 1'b1;
        to_int  = 1'b1;
      end
      OP_FMIN, OP_FMAX: use_cmp = 1'b1;
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX, OP_FMV_W_X: use_scu = 1'b1;
      OP_FCLASS, OP_FMV_X_W: begin
        use_scu = 1'b1;
        to_int  = 1'b1;
      end
      default: ;
    endcase
  end

  assign is_fp_op = use_cmp | use_scu;

  // ====================
  // Operation tracking
  // ====================
  logic                      busy;
  logic                      accept;
  logic                      any_done;
  logic                      cmp_start_q;
  logic                      scu_start_q;
  logic [REG_ADDR_WIDTH-1:0] dest_q;
  logic                      to_int_q;

  // Only one operation in flight across both units
  assign accept   = i_valid & is_fp_op & ~busy;
  assign any_done = cmp.done | scu.done;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy        <= 1'b0;
      cmp_start_q <= 1'b0;
      scu_start_q <= 1'b0;
      dest_q      <= '0;
      to_int_q    <= 1'b0;
    end else begin
      // Done wins so the held request is never issued twice
      if (any_done) begin
        busy <= 1'b0;
      end else if (accept) begin
        busy <= 1'b1;
      end
      // Start pulses one cycle after acceptance
      cmp_start_q <= accept & use_cmp;
      scu_start_q <= accept & use_scu;
      if (accept) begin
        dest_q   <= i_dest_reg;
        to_int_q <= to_int;
      end
    end
  end

  // Caller holds operation fields while stalled, so units see them at start
  assign cmp.start     = cmp_start_q;
  assign cmp.op        = i_operation;
  assign cmp.operand_a = i_operand_a;
  assign cmp.operand_b = i_operand_b;
  assign scu.start     = scu_start_q;
  assign scu.op        = i_operation;
  assign scu.operand_a = i_operand_a;
  assign scu.operand_b = i_operand_b;

  // ====================
  // Result and flags
  // ====================
  always_comb begin
    if (cmp.done) begin
      o_result = cmp.result;
    end else if (scu.done) begin
      o_result = scu.result;
    end else begin
      o_result = '0;
    end
  end

  // Only invalid-operation can be raised, nothing here divides or rounds
  always_comb begin
    o_flags          = '0;
    o_flags[FLAG_NV] = (cmp.done & cmp.nv) | (scu.done & scu.nv);
    o_flags[FLAG_DZ] = 1'b0;
    o_flags[FLAG_OF] = 1'b0;
    o_flags[FLAG_UF] = 1'b0;
    o_flags[FLAG_NX] = 1'b0;
  end

  assign o_valid         = any_done;
  assign o_result_to_int = any_done & to_int_q;
  assign o_dest_reg      = any_done ? dest_q : '0;

  // Stall from the acceptance cycle until the result cycle
  assign o_stall = (busy | (i_valid & is_fp_op)) & ~any_done;

  // Hazard unit sees the destination until the result leaves
  assign o_inflight_dest = (busy & ~any_done) ? dest_q : '0;

endmodule : fpu_sequencer

`default_nettype wire

// File: hw/fp_sign_class_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fp_sign_class_unit (
  input logic      i_clk,
  input logic      i_rst,
  fpu_unit_if.unit port
);
  import fp32_pkg::*;
  import fpu_op_pkg::*;

  // ====================
  // Stage 1: capture
  // ====================
  fp32_word_u          a1;
  fp32_word_u          b1;
  logic [OP_WIDTH-1:0] op1;
  logic                v1;

  always_ff @(posedge i_clk) begin
    if (port.start) begin
      a1  <= port.operand_a;
      b1  <= port.operand_b;
      op1 <= port.op;
    end
  end

  // ====================
  // Stage 2: compute
  // ====================
  logic                   exp_max;
  logic                   exp_zero;
  logic                   mant_zero;
  logic [CLASS_WIDTH-1:0] cls;
  logic [FP_WIDTH-1:0]    res_c;

  always_comb begin
    exp_max   = &a1.fields.exp;
    exp_zero  = a1.fields.exp == '0;
    mant_zero = a1.fields.mant == '0;
    cls       = '0;
    // One-hot class, sign picks the negative or positive half
    if (exp_max && mant_zero) begin
      cls[a1.fields.sign ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
    end else if (exp_max) begin
      cls[a1.fields.mant[MANT_WIDTH-1] ? CLS_QNAN : CLS_SNAN] = 1'b1;
    end else if (exp_zero && mant_zero) begin
      cls[a1.fields.sign ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
    end else if (exp_zero) begin
      cls[a1.fields.sign ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
    end else begin
      cls[a1.fields.sign ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
    end
  end

  always_comb begin
    // Moves pass the raw bit pattern of A
    res_c = a1.bits;
    case (op1)
      OP_FSGNJ:  res_c[FP_WIDTH-1] = b1.fields.sign;
      OP_FSGNJN: res_c[FP_WIDTH-1] = ~b1.fields.sign;
      OP_FSGNJX: res_c[FP_WIDTH-1] = a1.fields.sign ^ b1.fields.sign;
      OP_FCLASS: res_c = {{(FP_WIDTH-CLASS_WIDTH){1'b0}}, cls};
      default: ;
    endcase
  end

  always_ff @(posedge i_clk) begin
    port.result <= res_c;
  end

  // No operation here can be invalid
  assign port.nv = 1'b0;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      v1        <= 1'b0;
      port.done <= 1'b0;
    end else begin
      v1        <= port.start;
      port.done <= v1;
    end
  end

endmodule : fp_sign_class_unit

`default_nettype wire

// File: hw/fp_compare.sv
`timescale 1ns/1ps
`default_nettype none

module fp_compare (
  input logic      i_clk,
  input logic      i_rst,
  fpu_unit_if.unit port
);
  import fp32_pkg::*;
  import fpu_op_pkg::*;

  function automatic logic is_nan(input fp32_word_u w);
    return (&w.fields.exp) && (w.fields.mant != '0);
  endfunction

  // Signaling NaN has the quiet bit clear
  function automatic logic is_snan(input fp32_word_u w);
    return is_nan(w) && !w.fields.mant[MANT_WIDTH-1];
  endfunction

  function automatic logic is_zero(input fp32_word_u w);
    return (w.fields.exp == '0) && (w.fields.mant == '0);
  endfunction

  // ====================
  // Stage 1: capture and classify
  // ====================
  fp32_word_u          a_in;
  fp32_word_u          b_in;
  fp32_word_u          a1;
  fp32_word_u          b1;
  logic [OP_WIDTH-1:0] op1;
  logic                a1_nan;
  logic                b1_nan;
  logic                a1_snan;
  logic                b1_snan;
  logic                a1_zero;
  logic                b1_zero;
  logic                v1;

  assign a_in = port.operand_a;
  assign b_in = port.operand_b;

  always_ff @(posedge i_clk) begin
    if (port.start) begin
      a1      <= a_in;
      b1      <= b_in;
      op1     <= port.op;
      a1_nan  <= is_nan(a_in);
      b1_nan  <= is_nan(b_in);
      a1_snan <= is_snan(a_in);
      b1_snan <= is_snan(b_in);
      a1_zero <= is_zero(a_in);
      b1_zero <= is_zero(b_in);
    end
  end

  // ====================
  // Stage 2: order
  // ====================
  logic                both_zero;
  logic                mag_lt;
  logic                lt_c;
  logic                eq_c;
  fp32_word_u          a2;
  fp32_word_u          b2;
  logic [OP_WIDTH-1:0] op2;
  logic                a2_nan;
  logic                b2_nan;
  logic                snan2;
  logic                lt2;
  logic                eq2;
  logic                v2;

  always_comb begin
    both_zero = a1_zero & b1_zero;
    mag_lt    = a1.bits[FP_WIDTH-2:0] < b1.bits[FP_WIDTH-2:0];
    // +0 and -0 are equal here
    eq_c      = (a1.bits == b1.bits) | both_zero;
    if (a1.fields.sign != b1.fields.sign) begin
      lt_c = a1.fields.sign & ~both_zero;
    end else if (a1.fields.sign) begin
      // Both negative, larger magnitude is smaller
      lt_c = (a1.bits != b1.bits) & ~mag_lt;
    end else begin
      lt_c = mag_lt;
    end
  end

  always_ff @(posedge i_clk) begin
    a2     <= a1;
    b2     <= b1;
    op2    <= op1;
    a2_nan <= a1_nan;
    b2_nan <= b1_nan;
    snan2  <= a1_snan | b1_snan;
    lt2    <= lt_c;
    eq2    <= eq_c;
  end

  // ====================
  // Stage 3: result
  // ====================
  logic                any_nan;
  logic                min_a;
  logic [FP_WIDTH-1:0] res_c;
  logic                nv_c;

  always_comb begin
    any_nan = a2_nan | b2_nan;
    // For min/max -0 sorts below +0
    min_a   = lt2 | (eq2 & a2.fields.sign);
    res_c   = '0;
    nv_c    = 1'b0;
    case (op2)
      OP_FEQ: begin
        res_c[0] = eq2 & ~any_nan;
        nv_c     = snan2;
      end
      OP_FLT: begin
        res_c[0] = lt2 & ~any_nan;
        nv_c     = any_nan;
      end
      OP_FLE: begin
        res_c[0] = (lt2 | eq2) & ~any_nan;
        nv_c     = any_nan;
      end
      OP_FMIN, OP_FMAX: begin
        nv_c = snan2;
        if (a2_nan && b2_nan) res_c = CANONICAL_NAN;
        else if (a2_nan) res_c = b2.bits;
        else if (b2_nan) res_c = a2.bits;
        else if (min_a == (op2 == OP_FMIN)) res_c = a2.bits;
        else res_c = b2.bits;
      end
      default: ;
    endcase
  end

  always_ff @(posedge i_clk) begin
    port.result <= res_c;
    port.nv     <= nv_c;
  end

  // Valid bit walks alongside the data
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      v1        <= 1'b0;
      v2        <= 1'b0;
      port.done <= 1'b0;
    end else begin
      v1        <= port.start;
      v2        <= v1;
      port.done <= v2;
    end
  end

endmodule : fp_compare

`default_nettype wire

// File: hw/fpu_unit_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fpu_unit_if;
  import fp32_pkg::*;
  import fpu_op_pkg::*;

  // Request, sampled by the unit on the start pulse only
  logic                start;
  logic [OP_WIDTH-1:0] op;
  logic [FP_WIDTH-1:0] operand_a;
  logic [FP_WIDTH-1:0] operand_b;

  // Response, qualified by a one-cycle done pulse
  logic [FP_WIDTH-1:0] result;
  logic                nv;
  logic                done;

  // Sequencer side
  modport sequencer (
    output start, op, operand_a, operand_b,
    input  result, nv, done
  );

  // Execution unit side
  modport unit (
    input  start, op, operand_a, operand_b,
    output result, nv, done
  );

endinterface : fpu_unit_if

`default_nettype wire

// File: hw/fpu_op_pkg.sv
`default_nettype none

package fpu_op_pkg;

  // ====================
  // Operation codes
  // ====================
  localparam int OP_WIDTH = 5;

  // Compare unit
  localparam logic [OP_WIDTH-1:0] OP_FEQ     = 5'd1;
  localparam logic [OP_WIDTH-1:0] OP_FLT     = 5'd2;
  localparam logic [OP_WIDTH-1:0] OP_FLE     = 5'd3;
  localparam logic [OP_WIDTH-1:0] OP_FMIN    = 5'd4;
  localparam logic [OP_WIDTH-1:0] OP_FMAX    = 5'd5;
  // Sign/class unit
  localparam logic [OP_WIDTH-1:0] OP_FSGNJ   = 5'd6;
  localparam logic [OP_WIDTH-1:0] OP_FSGNJN  = 5'd7;
  localparam logic [OP_WIDTH-1:0] OP_FSGNJX  = 5'd8;
  localparam logic [OP_WIDTH-1:0] OP_FCLASS  = 5'd9;
  localparam logic [OP_WIDTH-1:0] OP_FMV_X_W = 5'd10;
  localparam logic [OP_WIDTH-1:0] OP_FMV_W_X = 5'd11;
  // Code 0 and codes 12 and up are not FP operations

  localparam int REG_ADDR_WIDTH = 5;

  // ====================
  // Exception flags
  // ====================
  localparam int FLAG_WIDTH = 5;
  localparam int FLAG_NV    = 4;
  localparam int FLAG_DZ    = 3;
  localparam int FLAG_OF    = 2;
  localparam int FLAG_UF    = 1;
  localparam int FLAG_NX    = 0;

endpackage : fpu_op_pkg

`default_nettype wire

// File: hw/fp32_pkg.sv
`default_nettype none

package fp32_pkg;

  // ====================
  // Format widths
  // ====================
  localparam int FP_WIDTH   = 32;
  localparam int EXP_WIDTH  = 8;
  localparam int MANT_WIDTH = 23;

  // One FP32 word, read either as raw bits or as IEEE 754 fields
  // Moves use the raw view, compare/sign/class use the field view
  typedef union packed {
    logic [FP_WIDTH-1:0] bits;
    struct packed {
      logic                  sign;
      logic [EXP_WIDTH-1:0]  exp;
      logic [MANT_WIDTH-1:0] mant;
    } fields;
  } fp32_word_u;

  // Quiet NaN with no payload
  localparam logic [FP_WIDTH-1:0] CANONICAL_NAN = 32'h7FC0_0000;

  // ====================
  // FCLASS result bits
  // ====================
  localparam int CLASS_WIDTH  = 10;
  localparam int CLS_NEG_INF  = 0;
  localparam int CLS_NEG_NORM = 1;
  localparam int CLS_NEG_SUB  = 2;
  localparam int CLS_NEG_ZERO = 3;
  localparam int CLS_POS_ZERO = 4;
  localparam int CLS_POS_SUB  = 5;
  localparam int CLS_POS_NORM = 6;
  localparam int CLS_POS_INF  = 7;
  localparam int CLS_SNAN     = 8;
  localparam int CLS_QNAN     = 9;

endpackage : fp32_pkg

`default_nettype wire
